// File: ext_power_hub.f
ext_power_hub_pkg.sv
apb_periph_demux.sv
power_seq_ctrl.sv
switch_ack_delay.sv
intr_collect.sv
ext_power_hub.sv
ext_power_hub_assertions.sv
tb_ext_power_hub.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ext_power_hub
FILELIST  ?= ext_power_hub.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: tb_ext_power_hub.sv
/*
 * Testbench for the external power hub: APB register traffic, domain
 * power cycling and external interrupt pulses
 */
module tb_ext_power_hub;
  timeunit 1ns;
  timeprecision 1ps;
  import ext_power_hub_pkg::*;

  logic                    clk;
  logic                    arst_n;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic [NEXT_EXT_INT-1:0] ext_intr;
  domain_ctrl_t            domain_ctrl;
  logic                    intr;
  logic [31:0]             lfsr_state = 32'h4885;

  ext_power_hub u_ext_power_hub (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .ext_intr_i    (ext_intr),
    .domain_ctrl_o (domain_ctrl),
    .intr_o        (intr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic apb_addr_t pwr_addr(input apb_addr_t ofs);
    return POWER_SLOT_BASE + ofs;
  endfunction

  function automatic apb_addr_t intr_addr(input apb_addr_t ofs);
    return INTR_SLOT_BASE + ofs;
  endfunction

  task automatic abort_run(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, got);
      abort_run("checked value differs from the expected value");
    end
  endtask

  // Response sampled on the falling edge after the access cycle
  task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata);
    int unsigned waits;
    waits = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      if (waits == 16) begin
        abort_run("timeout waiting for pready on an APB access");
      end
      waits++;
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    // Unmapped space starts at 0x200
    check_value("pslverr", apb_data_t'(apb_rsp.pslverr), apb_data_t'(addr >= 12'h200));
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t ignored;
    apb_xfer(1'b1, addr, wdata, ignored);
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t rd;
    apb_xfer(1'b0, addr, '0, rd);
    check_value(name, rd, exp);
  endtask

  task automatic wait_value(input apb_addr_t addr, input apb_data_t exp, input string what);
    apb_data_t   rd;
    int unsigned tries;
    tries = 0;
    apb_xfer(1'b0, addr, '0, rd);
    while (rd !== exp) begin
      if (tries == 100) begin
        abort_run({"timeout waiting for ", what});
      end
      tries++;
      apb_xfer(1'b0, addr, '0, rd);
    end
  endtask

  // First assertion failure ends the run
  always @(negedge clk) begin
    if (u_ext_power_hub.u_ext_power_hub_assertions.assert_failed) begin
      $display("mismatch at %0t: assert_failed expected 0 got 1", $time);
      abort_run("a concurrent assertion failed");
    end
  end

  initial begin
    logic [31:0] r;
    domain_vec_t first;
    domain_vec_t rest;
    intr_vec_t   mask;
    intr_vec_t   pend;
    intr_vec_t   clr;
    apb_req  = '0;
    ext_intr = '0;
    arst_n   = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    read_expect(pwr_addr(PWR_STATUS_OFS), '0, "pwr_status");

    // Random domain goes off first, then both
    draw_bits(1, r);
    first = r[0] ? 2'b10 : 2'b01;
    rest  = ~first;
    apb_write(pwr_addr(PWR_REQ_OFS), apb_data_t'(first));
    read_expect(pwr_addr(PWR_REQ_OFS), apb_data_t'(first), "pwr_req");
    wait_value(pwr_addr(PWR_STATUS_OFS), apb_data_t'(first), "first domain off");
    read_expect(intr_addr(INTR_STATUS_OFS), apb_data_t'(first), "intr_status");
    apb_write(pwr_addr(PWR_REQ_OFS), 32'h3);
    read_expect(pwr_addr(PWR_REQ_OFS), 32'h3, "pwr_req");
    wait_value(pwr_addr(PWR_STATUS_OFS), 32'h3, "both domains off");
    read_expect(intr_addr(INTR_STATUS_OFS), 32'h3, "intr_status");
    apb_write(intr_addr(INTR_STATUS_OFS), 32'h3);
    read_expect(intr_addr(INTR_STATUS_OFS), '0, "intr_status");

    // Power-on ends with the done bit
    apb_write(pwr_addr(PWR_REQ_OFS), apb_data_t'(rest));
    wait_value(intr_addr(INTR_STATUS_OFS), apb_data_t'(first), "first domain on");
    read_expect(pwr_addr(PWR_STATUS_OFS), apb_data_t'(rest), "pwr_status");
    apb_write(pwr_addr(PWR_REQ_OFS), '0);
    wait_value(intr_addr(INTR_STATUS_OFS), 32'h3, "both domains on");
    read_expect(pwr_addr(PWR_STATUS_OFS), '0, "pwr_status");
    apb_write(intr_addr(INTR_STATUS_OFS), 32'hf);

    for (int round = 0; round < 6; round++) begin
      draw_bits(4, r);
      mask = r[3:0];
      apb_write(intr_addr(INTR_ENABLE_OFS), apb_data_t'(mask));
      read_expect(intr_addr(INTR_ENABLE_OFS), apb_data_t'(mask), "intr_enable");
      draw_bits(2, r);
      @(negedge clk);
      ext_intr = r[1:0];
      @(negedge clk);
      ext_intr = '0;
      // External lines sit above the power-done bits
      pend = {r[1:0], 2'b00};
      read_expect(intr_addr(INTR_STATUS_OFS), apb_data_t'(pend), "intr_status");
      check_value("intr_o", apb_data_t'(intr), apb_data_t'(|(pend & mask)));
      draw_bits(4, r);
      clr = r[3:0];
      apb_write(intr_addr(INTR_STATUS_OFS), apb_data_t'(clr));
      pend = pend & ~clr;
      read_expect(intr_addr(INTR_STATUS_OFS), apb_data_t'(pend), "intr_status");
      check_value("intr_o", apb_data_t'(intr), apb_data_t'(|(pend & mask)));
      apb_write(intr_addr(INTR_STATUS_OFS), 32'hf);
    end

    for (int k = 0; k < 3; k++) begin
      draw_bits(12, r);
      read_expect(r[11:0] | 12'h200, '0, "prdata");
      apb_write(r[11:0] | 12'h200, r);
    end

    if (!u_ext_power_hub.u_ext_power_hub_assertions.assert_failed) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("a concurrent assertion failed");
    end
  end

endmodule

// File: ext_power_hub_assertions.sv
/*
 * Concurrent checks on the external power hub: APB responses, domain
 * sequencing safety and switch acknowledge latency
 */
module ext_power_hub_assertions (
  input logic                            clk_i,
  input logic                            arst_n_i,
  input ext_power_hub_pkg::apb_req_t     apb_req_i,
  input ext_power_hub_pkg::apb_rsp_t     apb_rsp_i,
  input ext_power_hub_pkg::domain_ctrl_t domain_ctrl_i,
  input logic                            intr_i,
  input ext_power_hub_pkg::domain_vec_t  switch_ack_ni
);
  timeunit 1ns;
  timeprecision 1ps;
  import ext_power_hub_pkg::*;

  logic                   access;
  int unsigned            run_cycles_q;
  logic                   reset_fail  = 1'b0;
  logic                   pready_fail = 1'b0;
  logic                   decode_fail = 1'b0;
  logic                   safe_fail   = 1'b0;
  logic                   ack_fail    = 1'b0;
  logic [EXT_DOMAINS-1:0] iso_fail;
  logic                   assert_failed;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign assert_failed = reset_fail | pready_fail | decode_fail | safe_fail |
                         ack_fail | (|iso_fail);

  // Cycles since reset release, enough history for the ack check
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_cycles_q <= 0;
    end else if (run_cycles_q < SWITCH_ACK_LATENCY) begin
      run_cycles_q <= run_cycles_q + 1;
    end
  end

  a_reset_values: assert property (@(posedge clk_i) $rose(arst_n_i) |->
      domain_ctrl_i.switch_n == '0 && domain_ctrl_i.iso_n == '1 &&
      domain_ctrl_i.rst_n == '1 && domain_ctrl_i.clkgate_en_n == '1 && !intr_i)
    else begin
      reset_fail = 1'b1;
      $error("domain control or interrupt line wrong after reset");
    end

  a_pready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      access |-> apb_rsp_i.pready)
    else begin
      pready_fail = 1'b1;
      $error("APB access phase without pready");
    end

  a_decode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      access |-> (apb_rsp_i.pslverr == (apb_req_i.paddr >= 12'h200)) &&
                 (apb_req_i.paddr < 12'h200 || apb_rsp_i.prdata == '0))
    else begin
      decode_fail = 1'b1;
      $error("wrong pslverr or read data for address %h", apb_req_i.paddr);
    end

  // A switched-off domain must be clamped, in reset and clock gated
  a_off_safe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (domain_ctrl_i.switch_n & (domain_ctrl_i.iso_n | domain_ctrl_i.rst_n |
                                 domain_ctrl_i.clkgate_en_n)) == '0)
    else begin
      safe_fail = 1'b1;
      $error("switch off while isolation, reset or clock gate released");
    end

  a_ack_delay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      run_cycles_q >= SWITCH_ACK_LATENCY |->
      switch_ack_ni == $past(domain_ctrl_i.switch_n, SWITCH_ACK_LATENCY))
    else begin
      ack_fail = 1'b1;
      $error("switch acknowledge does not follow switch_n after the latency");
    end

  for (genvar d = 0; d < EXT_DOMAINS; d++) begin : gen_iso
    int unsigned sw_low_q;
    logic        failed = 1'b0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        sw_low_q <= 0;
      end else if (domain_ctrl_i.switch_n[d]) begin
        sw_low_q <= 0;
      end else if (sw_low_q < SWITCH_ACK_LATENCY) begin
        sw_low_q <= sw_low_q + 1;
      end
    end

    a_iso_release: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(domain_ctrl_i.iso_n[d]) |-> sw_low_q >= SWITCH_ACK_LATENCY)
      else begin
        failed = 1'b1;
        $error("isolation released too early after switch on");
      end

    assign iso_fail[d] = failed;
  end

endmodule

bind ext_power_hub ext_power_hub_assertions u_ext_power_hub_assertions (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .apb_req_i     (apb_req_i),
  .apb_rsp_i     (apb_rsp_o),
  .domain_ctrl_i (domain_ctrl_o),
  .intr_i        (intr_o),
  .switch_ack_ni (switch_ack_n)
);

// File: ext_power_hub.sv
/*
 * External power-domain and interrupt hub behind one APB slave port
 */
module ext_power_hub (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  ext_power_hub_pkg::apb_req_t                apb_req_i,
  output ext_power_hub_pkg::apb_rsp_t                apb_rsp_o,
  input  logic [ext_power_hub_pkg::NEXT_EXT_INT-1:0] ext_intr_i,
  output ext_power_hub_pkg::domain_ctrl_t            domain_ctrl_o,
  output logic                                       intr_o
);
  import ext_power_hub_pkg::*;

  apb_req_t    power_req;
  apb_rsp_t    power_rsp;
  apb_req_t    intr_req;
  apb_rsp_t    intr_rsp;
  domain_vec_t switch_ack_n;
  domain_vec_t pwr_done;

  apb_periph_demux u_apb_periph_demux (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .power_req_o (power_req),
    .power_rsp_i (power_rsp),
    .intr_req_o  (intr_req),
    .intr_rsp_i  (intr_rsp)
  );

  power_seq_ctrl u_power_seq_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .apb_req_i     (power_req),
    .apb_rsp_o     (power_rsp),
    .switch_ack_ni (switch_ack_n),
    .domain_ctrl_o (domain_ctrl_o),
    .pwr_done_o    (pwr_done)
  );

  // Stand-in for the external switch cells
  switch_ack_delay u_switch_ack_delay (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .switch_ni     (domain_ctrl_o.switch_n),
    .switch_ack_no (switch_ack_n)
  );

  intr_collect u_intr_collect (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (intr_req),
    .apb_rsp_o  (intr_rsp),
    .pwr_done_i (pwr_done),
    .ext_intr_i (ext_intr_i),
    .intr_o     (intr_o)
  );

endmodule

// File: intr_collect.sv
/*
 * Interrupt collector: sticky status with write-one-to-clear,
 * enable mask and one combined interrupt line
 */
module intr_collect (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  ext_power_hub_pkg::apb_req_t                apb_req_i,
  output ext_power_hub_pkg::apb_rsp_t                apb_rsp_o,
  input  ext_power_hub_pkg::domain_vec_t             pwr_done_i,
  input  logic [ext_power_hub_pkg::NEXT_EXT_INT-1:0] ext_intr_i,
  output logic                                       intr_o
);
  import ext_power_hub_pkg::*;

  intr_vec_t status_q;
  intr_vec_t enable_q;
  intr_vec_t src;
  intr_vec_t clr;
  logic      access;
  logic      wr;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr     = access & apb_req_i.pwrite;
  assign src    = {ext_intr_i, pwr_done_i};
  assign clr    = (wr && apb_req_i.paddr == INTR_STATUS_OFS) ?
                  apb_req_i.pwdata[NEXT_INT-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
      enable_q <= '0;
    end else begin
      // Active source beats a clear in the same cycle
      status_q <= (status_q & ~clr) | src;
      if (wr && apb_req_i.paddr == INTR_ENABLE_OFS) begin
        enable_q <= apb_req_i.pwdata[NEXT_INT-1:0];
      end
    end
  end

  assign intr_o = |(status_q & enable_q);

  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = access;
    if (access && !apb_req_i.pwrite) begin
      if (apb_req_i.paddr == INTR_STATUS_OFS) begin
        apb_rsp_o.prdata = apb_data_t'(status_q);
      end else if (apb_req_i.paddr == INTR_ENABLE_OFS) begin
        apb_rsp_o.prdata = apb_data_t'(enable_q);
      end
    end
  end

endmodule

// File: switch_ack_delay.sv
/*
 * Power switch cell model, returns each switch enable as its
 * acknowledge a fixed number of cycles later
 */
module switch_ack_delay (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  ext_power_hub_pkg::domain_vec_t switch_ni,
  output ext_power_hub_pkg::domain_vec_t switch_ack_no
);
  import ext_power_hub_pkg::*;

  domain_vec_t ack_pipe_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '0;
      end
    end else begin
      ack_pipe_q[0] <= switch_ni;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  // Last stage is the cell acknowledge
  assign switch_ack_no = ack_pipe_q[SWITCH_ACK_LATENCY-1];

endmodule

// File: power_seq_ctrl.sv
/*
 * Power sequencer for the external domains: request and status registers
 * plus one off/on state machine per domain
 */
module power_seq_ctrl (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  ext_power_hub_pkg::apb_req_t     apb_req_i,
  output ext_power_hub_pkg::apb_rsp_t     apb_rsp_o,
  input  ext_power_hub_pkg::domain_vec_t  switch_ack_ni,
  output ext_power_hub_pkg::domain_ctrl_t domain_ctrl_o,
  output ext_power_hub_pkg::domain_vec_t  pwr_done_o
);
  import ext_power_hub_pkg::*;

  domain_vec_t pwr_req_q;
  domain_vec_t pwr_off;
  logic        access;
  logic        req_wr;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign req_wr = access & apb_req_i.pwrite & (apb_req_i.paddr == PWR_REQ_OFS);

  // A request arriving mid-sequence waits until ON or OFF is reached
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pwr_req_q <= '0;
    end else if (req_wr) begin
      pwr_req_q <= apb_req_i.pwdata[EXT_DOMAINS-1:0];
    end
  end

  for (genvar d = 0; d < EXT_DOMAINS; d++) begin : gen_domain
    pwr_state_e state_q;
    pwr_state_e state_d;
    logic       done_d;
    logic       done_q;

    always_comb begin
      state_d = state_q;
      done_d  = 1'b0;
      unique case (state_q)
        PWR_ON: begin
          if (pwr_req_q[d]) begin
            state_d = PWR_GATE_CLK;
          end
        end
        PWR_GATE_CLK:   state_d = PWR_ISOLATE;
        PWR_ISOLATE:    state_d = PWR_RESET;
        PWR_RESET:      state_d = PWR_SWITCH_OFF;
        PWR_SWITCH_OFF: begin
          // Switch cells report off
          if (switch_ack_ni[d]) begin
            state_d = PWR_OFF;
            done_d  = 1'b1;
          end
        end
        PWR_OFF: begin
          if (!pwr_req_q[d]) begin
            state_d = PWR_SWITCH_ON;
          end
        end
        PWR_SWITCH_ON: begin
          if (!switch_ack_ni[d]) begin
            state_d = PWR_RELEASE_RST;
          end
        end
        PWR_RELEASE_RST: state_d = PWR_RELEASE_ISO;
        PWR_RELEASE_ISO: begin
          state_d = PWR_ON;
          done_d  = 1'b1;
        end
        default: state_d = PWR_ON;
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q <= PWR_ON;
        done_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        done_q  <= done_d;
      end
    end

    assign domain_ctrl_o.switch_n[d] = state_q inside {PWR_SWITCH_OFF, PWR_OFF};
    assign domain_ctrl_o.rst_n[d] = state_q inside {PWR_ON, PWR_GATE_CLK, PWR_ISOLATE,
                                                     PWR_RELEASE_RST, PWR_RELEASE_ISO};
    assign domain_ctrl_o.iso_n[d] = state_q inside {PWR_ON, PWR_GATE_CLK, PWR_RELEASE_ISO};
    assign domain_ctrl_o.clkgate_en_n[d] = state_q inside {PWR_ON, PWR_RELEASE_ISO};

    assign pwr_off[d]    = (state_q == PWR_OFF);
    assign pwr_done_o[d] = done_q;
  end

  // Zero wait states
  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = access;
    if (access && !apb_req_i.pwrite) begin
      if (apb_req_i.paddr == PWR_REQ_OFS) begin
        apb_rsp_o.prdata = apb_data_t'(pwr_req_q);
      end else if (apb_req_i.paddr == PWR_STATUS_OFS) begin
        apb_rsp_o.prdata = apb_data_t'(pwr_off);
      end
    end
  end

endmodule

// File: apb_periph_demux.sv
/*
 * APB slot decoder: routes each transfer to the power or interrupt
 * register slot, answers unmapped addresses with an error
 */
module apb_periph_demux (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  ext_power_hub_pkg::apb_req_t apb_req_i,
  output ext_power_hub_pkg::apb_rsp_t apb_rsp_o,
  output ext_power_hub_pkg::apb_req_t power_req_o,
  input  ext_power_hub_pkg::apb_rsp_t power_rsp_i,
  output ext_power_hub_pkg::apb_req_t intr_req_o,
  input  ext_power_hub_pkg::apb_rsp_t intr_rsp_i
);
  import ext_power_hub_pkg::*;

  logic [APB_ADDR_W-SLOT_OFS_W-1:0] slot_idx;
  apb_addr_t                        slot_addr;
  logic                             access;
  logic                             hit_power_d;
  logic                             hit_intr_d;
  logic                             hit_power_q;
  logic                             hit_intr_q;
  logic                             hit_power;
  logic                             hit_intr;

  assign slot_idx    = apb_req_i.paddr[APB_ADDR_W-1:SLOT_OFS_W];
  assign slot_addr   = apb_addr_t'(apb_req_i.paddr[SLOT_OFS_W-1:0]);
  assign hit_power_d = (slot_idx == POWER_SLOT_BASE[APB_ADDR_W-1:SLOT_OFS_W]);
  assign hit_intr_d  = (slot_idx == INTR_SLOT_BASE[APB_ADDR_W-1:SLOT_OFS_W]);
  assign access      = apb_req_i.psel & apb_req_i.penable;

  // Slot picked in the setup phase holds through the access phase
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hit_power_q <= 1'b0;
      hit_intr_q  <= 1'b0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      hit_power_q <= hit_power_d;
      hit_intr_q  <= hit_intr_d;
    end
  end

  assign hit_power = access ? hit_power_q : hit_power_d;
  assign hit_intr  = access ? hit_intr_q : hit_intr_d;

  always_comb begin
    power_req_o       = apb_req_i;
    power_req_o.paddr = slot_addr;
    power_req_o.psel  = apb_req_i.psel & hit_power;
    intr_req_o        = apb_req_i;
    intr_req_o.paddr  = slot_addr;
    intr_req_o.psel   = apb_req_i.psel & hit_intr;
  end

  always_comb begin
    apb_rsp_o = '0;
    if (apb_req_i.psel) begin
      if (hit_power) begin
        apb_rsp_o = power_rsp_i;
      end else if (hit_intr) begin
        apb_rsp_o = intr_rsp_i;
      end else if (access) begin
        // Unmapped, error with zero data
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b1;
      end
    end
  end

endmodule

// File: ext_power_hub_pkg.sv
/*
 * External power hub definitions: sizes, APB register map, bus structs,
 * domain control bundle and power sequencer states
 */
package ext_power_hub_pkg;

  // Domain and interrupt counts
  localparam int unsigned EXT_DOMAINS        = 2;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NEXT_EXT_INT       = 2;
  // Power-done events first, external lines above them
  localparam int unsigned NEXT_INT           = EXT_DOMAINS + NEXT_EXT_INT;

  // APB bus
  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;
  // Offset bits inside one 0x100 register slot
  localparam int unsigned SLOT_OFS_W = 8;

  typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
  typedef logic [APB_DATA_W-1:0]  apb_data_t;
  typedef logic [EXT_DOMAINS-1:0] domain_vec_t;
  typedef logic [NEXT_INT-1:0]    intr_vec_t;

  // Slot bases, anything from 0x200 up is unmapped
  localparam apb_addr_t POWER_SLOT_BASE = 12'h000;
  localparam apb_addr_t INTR_SLOT_BASE  = 12'h100;

  // Power slot registers
  localparam apb_addr_t PWR_REQ_OFS    = 12'h000;
  localparam apb_addr_t PWR_STATUS_OFS = 12'h004;

  // Interrupt slot registers
  localparam apb_addr_t INTR_STATUS_OFS = 12'h000;
  localparam apb_addr_t INTR_ENABLE_OFS = 12'h004;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // All enables active low, one bit per domain
  typedef struct packed {
    domain_vec_t switch_n;
    domain_vec_t iso_n;
    domain_vec_t rst_n;
    domain_vec_t clkgate_en_n;
  } domain_ctrl_t;

  typedef enum logic [3:0] {
    PWR_ON,
    PWR_GATE_CLK,
    PWR_ISOLATE,
    PWR_RESET,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_RELEASE_RST,
    PWR_RELEASE_ISO
  } pwr_state_e;

endpackage
